// File: Makefile
# Verilator simulation of the N64 to HDMI video path

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f build.f --top-module n64_vid_tb -Mdir obj_dir
	./obj_dir/Vn64_vid_tb | tee /dev/stderr | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

// File: build.f
source/n64_vid_pkg.sv
source/hdmi_out_pkg.sv
source/n64_vid_demux.sv
source/pixel_scanline_proc.sv
source/hdmi_out_regs.sv
source/n64_vid_top.sv
dv/n64_vid_tb_sva.sv
dv/n64_vid_tb.sv

// File: dv/n64_vid_tb.sv
/*
 * Testbench for the N64 to HDMI video path
 * Table of groups applied in a loop, sync and pixel checks
 * three edges after the input cycle, timeout and summary
 */

`timescale 1ns/1ps

module n64_vid_tb
  import n64_vid_pkg::*;
  import hdmi_out_pkg::*;
();

  localparam int NUM_TESTS   = 14;
  // At most 4 group cycles plus 4 idle cycles per entry
  localparam int CYCLE_LIMIT = NUM_TESTS * 2 * PHASES_PER_PIXEL + 20;

  // DUT ports
  logic                HDMI_CLK_w;
  logic                HDMI_nRST_w;
  logic                nVDSYNC_i;
  logic [VD_WIDTH-1:0] VD_i;
  logic                scanline_en_i;
  logic                VSYNC_o;
  logic                HSYNC_o;
  logic                DE_o;
  logic [RGB_W_O-1:0]  VD_o;

  // Stimulus table
  n64_vd_word_u        tb_sync [NUM_TESTS];
  logic [VD_WIDTH-1:0] tb_r    [NUM_TESTS];
  logic [VD_WIDTH-1:0] tb_g    [NUM_TESTS];
  logic [VD_WIDTH-1:0] tb_b    [NUM_TESTS];
  logic                tb_scan [NUM_TESTS];
  // Extra idle cycle before the group
  logic                tb_late [NUM_TESTS];
  // Expected values
  logic                exp_v   [NUM_TESTS];
  logic                exp_h   [NUM_TESTS];
  logic                exp_de  [NUM_TESTS];
  logic [RGB_W_O-1:0]  exp_vd  [NUM_TESTS];

  int   seed;
  int   error_count;
  int   test_count;
  logic test_failed;

  n64_vid_top dut (
    .HDMI_CLK_w    (HDMI_CLK_w),
    .HDMI_nRST_w   (HDMI_nRST_w),
    .nVDSYNC_i     (nVDSYNC_i),
    .VD_i          (VD_i),
    .scanline_en_i (scanline_en_i),
    .VSYNC_o       (VSYNC_o),
    .HSYNC_o       (HSYNC_o),
    .DE_o          (DE_o),
    .VD_o          (VD_o)
  );

  initial begin
    HDMI_CLK_w = 1'b0;
    forever #2 HDMI_CLK_w = ~HDMI_CLK_w;
  end

  //////////////////////////////////////////////////
  // Reference rules
  //////////////////////////////////////////////////

  // Top bit appended below, then halved on dimmed lines
  function automatic logic [COLOR_W_O-1:0] expand_color(input logic [VD_WIDTH-1:0] c,
                                                        input logic                dim);
    logic [COLOR_W_O-1:0] w;
    w = {c, c[VD_WIDTH-1]};
    if (dim) begin
      w = w >> SCANLINE_SHIFT;
    end
    return w;
  endfunction

  task automatic set_entry(input int i, input logic [3:0] nib, input logic [6:0] r,
                           input logic [6:0] g, input logic [6:0] b,
                           input logic scan, input logic late);
    tb_sync[i] = {3'b000, nib};
    tb_r[i]    = r;
    tb_g[i]    = g;
    tb_b[i]    = b;
    tb_scan[i] = scan;
    tb_late[i] = late;
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    logic        odd;
    logic        prev_h;
    logic        dim;
    // Widening, sync flag by flag, then dimming
    set_entry(0, 4'hF, 7'h7F, 7'h00, 7'h40, 1'b0, 1'b0);
    set_entry(1, 4'hF, 7'h2A, 7'h15, 7'h55, 1'b0, 1'b0);
    set_entry(2, 4'h7, 7'h01, 7'h02, 7'h03, 1'b0, 1'b0);
    set_entry(3, 4'hB, 7'h41, 7'h42, 7'h43, 1'b0, 1'b0);
    set_entry(4, 4'hD, 7'h7F, 7'h7E, 7'h3F, 1'b1, 1'b0);
    set_entry(5, 4'hC, 7'h60, 7'h31, 7'h0F, 1'b1, 1'b0);
    set_entry(6, 4'hF, 7'h55, 7'h2A, 7'h7F, 1'b1, 1'b0);
    // Misaligned group, one idle cycle late
    set_entry(7, 4'hD, 7'h12, 7'h34, 7'h56, 1'b1, 1'b1);
    // Random filler on alternating lines
    for (int i = 8; i < NUM_TESTS; i++) begin
      rnd = $random(seed);
      set_entry(i, (i % 2 == 0) ? 4'hF : 4'hD, rnd[6:0], rnd[14:8], rnd[22:16], 1'b1, 1'b0);
    end
    // Line parity follows hsync_n falls between sync words
    odd    = 1'b0;
    prev_h = 1'b0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      exp_v[i]  = !tb_sync[i].sync.vsync_n;
      exp_h[i]  = !tb_sync[i].sync.hsync_n;
      exp_de[i] = tb_sync[i].sync.vsync_n && tb_sync[i].sync.hsync_n
                  && tb_sync[i].sync.clamp_n;
      if (prev_h && !tb_sync[i].sync.hsync_n) begin
        odd = !odd;
      end
      prev_h    = tb_sync[i].sync.hsync_n;
      dim       = tb_scan[i] && odd;
      exp_vd[i] = {expand_color(tb_r[i], dim), expand_color(tb_g[i], dim),
                   expand_color(tb_b[i], dim)};
    end
  endtask

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_sync(input n64_vd_word_u word, input logic ev, input logic eh,
                            input logic ede);
    if (VSYNC_o !== ev || HSYNC_o !== eh || DE_o !== ede) begin
      $display("Fail %0t: sync %h gave V=%b H=%b DE=%b, expected V=%b H=%b DE=%b",
               $time, word, VSYNC_o, HSYNC_o, DE_o, ev, eh, ede);
      error_count++;
      test_failed = 1'b1;
    end
  endtask

  task automatic check_color(input logic [RGB_W_O-1:0] exp, input string what);
    if (VD_o !== exp) begin
      $display("Fail %0t: %s VD_o=%h, expected %h", $time, what, VD_o, exp);
      error_count++;
      test_failed = 1'b1;
    end
  endtask

  task automatic drive_bus(input logic marker, input logic [VD_WIDTH-1:0] word);
    nVDSYNC_i = marker;
    VD_i      = word;
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    HDMI_nRST_w   = 1'b0;
    nVDSYNC_i     = 1'b1;
    VD_i          = '0;
    scanline_en_i = 1'b0;
    seed          = 32'h34a48199;
    error_count   = 0;
    test_count    = 0;
    build_table();

    // Reset state, then idle before the first sync word
    test_failed = 1'b0;
    repeat (3) begin
      @(negedge HDMI_CLK_w);
      check_sync('1, 1'b0, 1'b0, 1'b0);
      check_color('0, "in reset");
    end
    HDMI_nRST_w = 1'b1;
    @(negedge HDMI_CLK_w);
    check_sync('1, 1'b0, 1'b0, 1'b0);
    check_color('0, "before first sync");
    test_count++;
    $display("reset test %s", test_failed ? "failed" : "ok");

    for (int i = 0; i < NUM_TESTS; i++) begin
      test_failed   = 1'b0;
      scanline_en_i = tb_scan[i];
      if (tb_late[i]) begin
        drive_bus(1'b1, '0);
        @(negedge HDMI_CLK_w);
      end
      drive_bus(1'b0, tb_sync[i]);
      @(negedge HDMI_CLK_w);
      drive_bus(1'b1, tb_r[i]);
      @(negedge HDMI_CLK_w);
      drive_bus(1'b1, tb_g[i]);
      @(negedge HDMI_CLK_w);
      drive_bus(1'b1, tb_b[i]);
      @(negedge HDMI_CLK_w);
      // Sync result lands 3 edges after the sync cycle
      check_sync(tb_sync[i], exp_v[i], exp_h[i], exp_de[i]);
      // Late group lets an idle pixel through, so no hold check there
      if (i > 0 && !tb_late[i]) begin
        check_color(exp_vd[i-1], "hold of previous pixel");
      end
      drive_bus(1'b1, '0);
      repeat (3) @(negedge HDMI_CLK_w);
      // Pixel lands 3 edges after blue
      check_color(exp_vd[i], "pixel");
      test_count++;
      $display("test %0d %s", i, test_failed ? "failed" : "ok");
    end

    // Add failures of the bound assertions
    error_count += dut.u_sva.assert_fails;
    $display("%0d tests run, %0d errors", test_count, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Run limit
  initial begin
    repeat (CYCLE_LIMIT) @(posedge HDMI_CLK_w);
    $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: dv/n64_vid_tb_sva.sv
/*
 * Video path assertions
 * Strobe spacing, DE against syncs and output reset state
 */

`timescale 1ns/1ps

module n64_vid_tb_sva
  import hdmi_out_pkg::*;
(
  input logic               HDMI_CLK_w,
  input logic               HDMI_nRST_w,
  input logic               pix_valid,
  input logic               VSYNC_o,
  input logic               HSYNC_o,
  input logic               DE_o,
  input logic [RGB_W_O-1:0] VD_o
);

  // Number of failed assertions
  int assert_fails = 0;

  //////////////////////////////////////////////////
  // Demux strobe
  //////////////////////////////////////////////////

  // One pixel per 4-cycle group at most
  pix_single_a : assert property (
    @(posedge HDMI_CLK_w) disable iff (!HDMI_nRST_w)
    pix_valid |=> !pix_valid
  ) else begin
    $error("pix_valid high in two consecutive cycles");
    assert_fails++;
  end

  //////////////////////////////////////////////////
  // Output pins
  //////////////////////////////////////////////////

  // Active video only outside sync
  de_blank_a : assert property (
    @(posedge HDMI_CLK_w) disable iff (!HDMI_nRST_w)
    DE_o |-> !(HSYNC_o || VSYNC_o)
  ) else begin
    $error("DE_o high while HSYNC_o or VSYNC_o is high");
    assert_fails++;
  end

  // Quiet outputs in reset
  reset_quiet_a : assert property (
    @(posedge HDMI_CLK_w)
    !HDMI_nRST_w |-> (!VSYNC_o && !HSYNC_o && !DE_o && (VD_o == '0))
  ) else begin
    $error("Outputs not zero while reset is low");
    assert_fails++;
  end

endmodule

bind n64_vid_top n64_vid_tb_sva u_sva (
  .HDMI_CLK_w  (HDMI_CLK_w),
  .HDMI_nRST_w (HDMI_nRST_w),
  .pix_valid   (pix_valid),
  .VSYNC_o     (VSYNC_o),
  .HSYNC_o     (HSYNC_o),
  .DE_o        (DE_o),
  .VD_o        (VD_o)
);

// File: source/hdmi_out_pkg.sv
/*
 * HDMI output side definitions
 * Output color width, packed RGB width and scanline dimming shift
 */

package hdmi_out_pkg;

  //////////////////////////////////////////////////
  // Output pixel format
  //////////////////////////////////////////////////

  // Bits per color towards the transmitter
  localparam int COLOR_W_O = 8;

  // Packed pixel, red in the top byte, blue in the bottom
  localparam int RGB_W_O = 3 * COLOR_W_O;

  //////////////////////////////////////////////////
  // Scanline effect
  //////////////////////////////////////////////////

  // Right shift on dimmed lines
  // One bit halves the intensity
  localparam int SCANLINE_SHIFT = 1;

endpackage

// File: source/hdmi_out_regs.sv
/*
 * HDMI output registers
 * Forms VSYNC, HSYNC and DE from the sync word and holds
 * the last pixel on VD until the next one arrives
 */

`timescale 1ns/1ps

module hdmi_out_regs
  import n64_vid_pkg::*;
  import hdmi_out_pkg::*;
(
  input  logic               HDMI_CLK_w,
  input  logic               HDMI_nRST_w,
  // Sync word
  input  logic               sync_valid_i,
  input  n64_vd_word_u       sync_i,
  // Pixel
  input  logic               px_valid_i,
  input  logic [RGB_W_O-1:0] rgb_i,
  // Transmitter pins
  output logic               VSYNC_o,
  output logic               HSYNC_o,
  output logic               DE_o,
  output logic [RGB_W_O-1:0] VD_o
);

  //////////////////////////////////////////////////
  // Output stage
  //////////////////////////////////////////////////

  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_w) begin
    if (!HDMI_nRST_w) begin
      VSYNC_o <= 1'b0;
      HSYNC_o <= 1'b0;
      DE_o    <= 1'b0;
      VD_o    <= '0;
    end else begin
      // Active-high syncs towards the transmitter
      if (sync_valid_i) begin
        VSYNC_o <= !sync_i.sync.vsync_n;
        HSYNC_o <= !sync_i.sync.hsync_n;
        // Blanked while any of vsync, hsync or clamp is asserted
        DE_o    <= sync_i.sync.vsync_n && sync_i.sync.hsync_n && sync_i.sync.clamp_n;
      end
      // Pixel held through the sync cycles
      if (px_valid_i) begin
        VD_o <= rgb_i;
      end
    end
  end

endmodule

// File: source/n64_vid_demux.sv
/*
 * N64 video bus demultiplexer
 * Registers the bus and splits each 4-cycle group into one
 * sync word and three color samples with single-cycle strobes
 */

`timescale 1ns/1ps

module n64_vid_demux
  import n64_vid_pkg::*;
(
  input  logic                HDMI_CLK_w,
  input  logic                HDMI_nRST_w,
  // N64 video bus
  input  logic                nVDSYNC_i,
  input  logic [VD_WIDTH-1:0] VD_i,
  // Sync word out
  output logic                sync_valid_o,
  output n64_vd_word_u        sync_o,
  // Color samples out
  output logic                pix_valid_o,
  output logic [VD_WIDTH-1:0] r_o,
  output logic [VD_WIDTH-1:0] g_o,
  output logic [VD_WIDTH-1:0] b_o
);

  // Registered bus
  logic         nvdsync_q;
  n64_vd_word_u vd_q;

  // Phase tracking
  logic [PHASE_W-1:0] phase_q;
  logic [PHASE_W-1:0] phase_cur;
  // Set by the first sync word after reset
  logic               synced_q;

  //////////////////////////////////////////////////
  // Input registers
  //////////////////////////////////////////////////

  // Marker idles high
  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_w) begin
    if (!HDMI_nRST_w) begin
      nvdsync_q <= 1'b1;
    end else begin
      nvdsync_q <= nVDSYNC_i;
    end
  end

  always_ff @(posedge HDMI_CLK_w) begin
    vd_q <= VD_i;
  end

  //////////////////////////////////////////////////
  // Phase decoder
  //////////////////////////////////////////////////

  // A registered low marker forces phase 0
  assign phase_cur = nvdsync_q ? phase_q : '0;

  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_w) begin
    if (!HDMI_nRST_w) begin
      phase_q      <= '0;
      synced_q     <= 1'b0;
      sync_valid_o <= 1'b0;
      pix_valid_o  <= 1'b0;
    end else begin
      // Free running, restarted by every sync word
      phase_q <= phase_cur + 1'b1;
      if (!nvdsync_q) begin
        synced_q <= 1'b1;
      end
      sync_valid_o <= !nvdsync_q;
      // Group complete once blue is in
      pix_valid_o  <= synced_q && nvdsync_q && (phase_cur == PH_BLUE);
    end
  end

  //////////////////////////////////////////////////
  // Sample latches
  //////////////////////////////////////////////////

  always_ff @(posedge HDMI_CLK_w) begin
    // Sync view in phase 0
    if (!nvdsync_q) begin
      sync_o <= vd_q;
    end
    // Color view in phases 1 to 3
    if (synced_q && nvdsync_q) begin
      case (phase_cur)
        PH_RED:   r_o <= vd_q.color;
        PH_GREEN: g_o <= vd_q.color;
        PH_BLUE:  b_o <= vd_q.color;
        default:  ;
      endcase
    end
  end

endmodule

// File: source/n64_vid_pkg.sv
/*
 * N64 video input definitions
 * Bus widths, pixel group phasing and the dual-view input word
 * used by the HDMI-domain video path
 */

package n64_vid_pkg;

  //////////////////////////////////////////////////
  // N64 digital video bus
  //////////////////////////////////////////////////

  // Width of VD_i
  localparam int VD_WIDTH = 7;

  // Bus cycles per group (sync, red, green, blue)
  localparam int PHASES_PER_PIXEL = 4;

  // Phase counter width
  localparam int PHASE_W = $clog2(PHASES_PER_PIXEL);

  // Phase of each color sample within a group
  // Phase 0 is the sync word, marked by a low nVDSYNC
  localparam logic [PHASE_W-1:0] PH_RED   = PHASE_W'(1);
  localparam logic [PHASE_W-1:0] PH_GREEN = PHASE_W'(2);
  localparam logic [PHASE_W-1:0] PH_BLUE  = PHASE_W'(PHASES_PER_PIXEL - 1);

  //////////////////////////////////////////////////
  // Input word, read either as color or as sync
  //////////////////////////////////////////////////

  typedef union packed {
    // Color sample in phases 1 to 3
    logic [VD_WIDTH-1:0] color;
    // Sync nibble in phase 0, all flags active low
    struct packed {
      logic [2:0] pad;
      logic       vsync_n;
      logic       clamp_n;
      logic       hsync_n;
      logic       csync_n;
    } sync;
  } n64_vd_word_u;

endpackage

// File: source/n64_vid_top.sv
/*
 * N64 to HDMI video path
 * Demux, pixel processing and output registers in the
 * HDMI clock domain
 */

`timescale 1ns/1ps

module n64_vid_top
  import n64_vid_pkg::*;
  import hdmi_out_pkg::*;
(
  input  logic                HDMI_CLK_w,
  input  logic                HDMI_nRST_w,
  // N64 video bus
  input  logic                nVDSYNC_i,
  input  logic [VD_WIDTH-1:0] VD_i,
  input  logic                scanline_en_i,
  // HDMI transmitter
  output logic                VSYNC_o,
  output logic                HSYNC_o,
  output logic                DE_o,
  output logic [RGB_W_O-1:0]  VD_o
);

  //////////////////////////////////////////////////
  // Interconnect
  //////////////////////////////////////////////////

  // Demux to processing
  logic                sync_valid;
  n64_vd_word_u        sync_word;
  logic                pix_valid;
  logic [VD_WIDTH-1:0] r_px;
  logic [VD_WIDTH-1:0] g_px;
  logic [VD_WIDTH-1:0] b_px;

  // Processing to output registers
  logic                sync_valid_d;
  n64_vd_word_u        sync_word_d;
  logic                px_valid;
  logic [RGB_W_O-1:0]  px_rgb;

  // Input side
  n64_vid_demux u_demux (
    .HDMI_CLK_w   (HDMI_CLK_w),
    .HDMI_nRST_w  (HDMI_nRST_w),
    .nVDSYNC_i    (nVDSYNC_i),
    .VD_i         (VD_i),
    .sync_valid_o (sync_valid),
    .sync_o       (sync_word),
    .pix_valid_o  (pix_valid),
    .r_o          (r_px),
    .g_o          (g_px),
    .b_o          (b_px)
  );

  // Widening and scanlines
  pixel_scanline_proc u_proc (
    .HDMI_CLK_w    (HDMI_CLK_w),
    .HDMI_nRST_w   (HDMI_nRST_w),
    .scanline_en_i (scanline_en_i),
    .sync_valid_i  (sync_valid),
    .sync_i        (sync_word),
    .pix_valid_i   (pix_valid),
    .r_i           (r_px),
    .g_i           (g_px),
    .b_i           (b_px),
    .sync_valid_o  (sync_valid_d),
    .sync_o        (sync_word_d),
    .px_valid_o    (px_valid),
    .rgb_o         (px_rgb)
  );

  // Output side
  hdmi_out_regs u_out (
    .HDMI_CLK_w   (HDMI_CLK_w),
    .HDMI_nRST_w  (HDMI_nRST_w),
    .sync_valid_i (sync_valid_d),
    .sync_i       (sync_word_d),
    .px_valid_i   (px_valid),
    .rgb_i        (px_rgb),
    .VSYNC_o      (VSYNC_o),
    .HSYNC_o      (HSYNC_o),
    .DE_o         (DE_o),
    .VD_o         (VD_o)
  );

endmodule

// File: source/pixel_scanline_proc.sv
/*
 * Pixel processing
 * Widens 7-bit colors to 8 bits, tracks line parity from the
 * sync words and halves odd lines when scanlines are on
 */

`timescale 1ns/1ps

module pixel_scanline_proc
  import n64_vid_pkg::*;
  import hdmi_out_pkg::*;
(
  input  logic                HDMI_CLK_w,
  input  logic                HDMI_nRST_w,
  input  logic                scanline_en_i,
  // From demux
  input  logic                sync_valid_i,
  input  n64_vd_word_u        sync_i,
  input  logic                pix_valid_i,
  input  logic [VD_WIDTH-1:0] r_i,
  input  logic [VD_WIDTH-1:0] g_i,
  input  logic [VD_WIDTH-1:0] b_i,
  // To output registers
  output logic                sync_valid_o,
  output n64_vd_word_u        sync_o,
  output logic                px_valid_o,
  output logic [RGB_W_O-1:0]  rgb_o
);

  // Line parity, high on odd lines
  logic line_odd_q;
  // hsync_n of the previous sync word
  logic hsync_prev_q;
  // Dimming active for the current pixel
  logic dim;

  // Top bits repeated below the LSB
  function automatic logic [COLOR_W_O-1:0] widen(input logic [VD_WIDTH-1:0] c);
    return {c, c[VD_WIDTH-1 -: (COLOR_W_O - VD_WIDTH)]};
  endfunction

  // Widen, then shift down on dimmed lines
  function automatic logic [COLOR_W_O-1:0] map_color(input logic [VD_WIDTH-1:0] c,
                                                     input logic                d);
    logic [COLOR_W_O-1:0] w;
    w = widen(c);
    return d ? (w >> SCANLINE_SHIFT) : w;
  endfunction

  assign dim = scanline_en_i && line_odd_q;

  //////////////////////////////////////////////////
  // Line parity
  //////////////////////////////////////////////////

  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_w) begin
    if (!HDMI_nRST_w) begin
      line_odd_q   <= 1'b0;
      // No fall counted before the first sync word
      hsync_prev_q <= 1'b0;
    end else if (sync_valid_i) begin
      // New line on hsync_n falling between sync words
      if (hsync_prev_q && !sync_i.sync.hsync_n) begin
        line_odd_q <= !line_odd_q;
      end
      hsync_prev_q <= sync_i.sync.hsync_n;
    end
  end

  //////////////////////////////////////////////////
  // Pipeline stage
  //////////////////////////////////////////////////

  always_ff @(posedge HDMI_CLK_w or negedge HDMI_nRST_w) begin
    if (!HDMI_nRST_w) begin
      sync_valid_o <= 1'b0;
      px_valid_o   <= 1'b0;
    end else begin
      sync_valid_o <= sync_valid_i;
      px_valid_o   <= pix_valid_i;
    end
  end

  // Payload follows its strobe
  always_ff @(posedge HDMI_CLK_w) begin
    sync_o <= sync_i;
    rgb_o  <= {map_color(r_i, dim), map_color(g_i, dim), map_color(b_i, dim)};
  end

endmodule
